/* build.f */
hw/soc_pkg.sv
hw/bus_decoder.sv
hw/bram.sv
hw/uart.sv
hw/clint.sv
hw/soc.sv
verif/soc_tb.sv

/* Bender.yml */
package:
  name: soc

sources:
  - hw/soc_pkg.sv
  - hw/bus_decoder.sv
  - hw/bram.sv
  - hw/uart.sv
  - hw/clint.sv
  - hw/soc.sv
  - target: test
    files:
      - verif/soc_tb.sv

/* verif/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb import soc_pkg::*; ();

  logic              clk;
  logic              arst_n;
  logic              mem_valid;
  logic [xlen-1:0]   mem_addr;
  logic [xlen-1:0]   mem_wdata;
  logic [xlen/8-1:0] mem_wstrb;
  logic [xlen-1:0]   mem_rdata;
  logic              mem_ready;
  logic              rx;
  logic              tx;
  logic              msip;
  logic              mtip;
  logic [63:0]       mtime;

  localparam int ready_timeout = 40 * clks_per_bit;
  localparam int start_timeout = 20 * clks_per_bit;

  logic [31:0]     lfsr = 32'h6d1c_c0da;
  logic [xlen-1:0] shadow [2**bram_depth];
  string           cur_test = "init";
  int              errors = 0;
  int              checks = 0;
  int              errors_at_start = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  int              cycle = 0;
  int              ready_cycle = 0;
  int              requests = 0;
  int              ready_pulses = 0;

  soc DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .rx        (rx),
    .tx        (tx),
    .msip      (msip),
    .mtip      (mtip),
    .mtime     (mtime)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  always @(negedge clk) begin
    if (arst_n && mem_ready) begin
      ready_pulses++;
    end
  end

  a_ready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    mem_ready |=> !mem_ready)
    else begin
      errors++;
      $display("%s: mem_ready stayed high for more than one cycle", cur_test);
    end

  a_ready_after_valid: assert property (@(posedge clk) disable iff (!arst_n)
    mem_ready |-> $past(mem_valid))
    else begin
      errors++;
      $display("%s: mem_ready rose without a request", cur_test);
    end

  ////////////////////
  // Helpers

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32 + x^22 + x^2 + x + 1.
      lfsr = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  // Random upper bits alias the same BRAM word unless they hit an I/O window.
  function automatic logic [xlen-1:0] bram_alias(input logic [bram_depth-1:0] idx);
    logic [xlen-1:0] addr;
    addr = rand_bits(xlen - bram_depth - 2) << (bram_depth + 2);
    addr[bram_depth+1:0] = {idx, 2'b00};
    if ((addr >= uart_base_addr && addr < uart_top_addr) ||
        (addr >= clint_base_addr && addr < clint_top_addr)) begin
      addr[xlen-1:bram_depth+2] = '0;
    end
    return addr;
  endfunction

  task automatic give_up(input string why);
    $display("Timeout in %s: %s", cur_test, why);
    $display("Test failures found");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("%s: %s", cur_test, what);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("%s: PASS", cur_test);
    end else begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  // Called on a falling edge, returns on a falling edge with valid low for a cycle.
  task automatic access(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                        input logic [xlen/8-1:0] strb, output logic [xlen-1:0] rdata);
    int waited;
    waited = 0;
    mem_valid = 1'b1;
    mem_addr = addr;
    mem_wdata = data;
    mem_wstrb = strb;
    @(negedge clk);
    while (mem_ready !== 1'b1) begin
      waited++;
      if (waited > ready_timeout) begin
        give_up("no ready on the memory port");
      end
      @(negedge clk);
    end
    rdata = mem_rdata;
    ready_cycle = cycle;
    requests++;
    mem_valid = 1'b0;
    mem_wstrb = '0;
    @(negedge clk);
  endtask

  task automatic write_word(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                            input logic [xlen/8-1:0] strb);
    logic [xlen-1:0] unused;
    access(addr, data, strb, unused);
  endtask

  task automatic read_word(input logic [xlen-1:0] addr, output logic [xlen-1:0] data);
    access(addr, '0, '0, data);
  endtask

  task automatic capture_tx_frame(output logic [7:0] data, output logic stop_bit);
    int waited;
    waited = 0;
    data = '0;
    while (tx !== 1'b0) begin
      waited++;
      if (waited > start_timeout) begin
        give_up("no start bit on tx");
      end
      @(negedge clk);
    end
    repeat (clks_per_bit / 2) @(negedge clk); // Middle of the start bit.
    check_value("tx start bit", 1'b0, tx);
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      data[i] = tx;
    end
    repeat (clks_per_bit) @(negedge clk);
    stop_bit = tx;
  endtask

  task automatic drive_rx_frame(input logic [7:0] data);
    rx = 1'b0;
    repeat (clks_per_bit) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = data[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    rx = 1'b1;
    repeat (clks_per_bit) @(negedge clk);
  endtask

  ////////////////////
  // Tests

  initial begin
    logic [bram_depth-1:0] idx_tab [8];
    logic [bram_depth-1:0] idx;
    logic [xlen-1:0]       data;
    logic [xlen-1:0]       rd;
    logic [xlen/8-1:0]     strb;
    logic [7:0]            byte_a;
    logic [7:0]            byte_b;
    logic [7:0]            got_a;
    logic [7:0]            got_b;
    logic                  stop_a;
    logic                  stop_b;
    logic [31:0]           t0;
    logic [31:0]           t1;
    logic [31:0]           target;
    int                    c0;
    int                    c1;
    int                    waited;

    arst_n = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    rx = 1'b1;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    start_test("reset");
    check_value("mem_ready", 1'b0, mem_ready);
    check_value("msip", 1'b0, msip);
    check_value("mtip", 1'b0, mtip);
    check_value("tx", 1'b1, tx);
    end_test();

    start_test("bram");
    for (int k = 0; k < 8; k++) begin
      idx_tab[k] = bram_depth'(rand_bits(bram_depth));
      data = rand_bits(xlen);
      write_word(bram_alias(idx_tab[k]), data, '1);
      shadow[idx_tab[k]] = data;
    end
    for (int n = 0; n < 32; n++) begin
      idx = idx_tab[rand_bits(3)];
      strb = (xlen/8)'(rand_bits(xlen/8));
      if (strb == '0) begin
        read_word(bram_alias(idx), rd);
        check_value("word", shadow[idx], rd);
      end else begin
        data = rand_bits(xlen);
        write_word(bram_alias(idx), data, strb);
        for (int b = 0; b < xlen/8; b++) begin
          if (strb[b]) begin
            shadow[idx][8*b +: 8] = data[8*b +: 8];
          end
        end
      end
    end
    for (int k = 0; k < 8; k++) begin
      read_word(bram_alias(idx_tab[k]), rd);
      check_value("final word", shadow[idx_tab[k]], rd);
    end
    end_test();

    start_test("uart_tx");
    byte_a = 8'(rand_bits(8));
    fork
      capture_tx_frame(got_a, stop_a);
      begin
        write_word(uart_base_addr + uart_data_offset, {24'h0, byte_a}, 4'h1);
        read_word(uart_base_addr + uart_status_offset, rd);
        check_value("busy during frame", 1'b1, rd[0]);
      end
    join
    check_value("byte", byte_a, got_a);
    check_value("stop bit", 1'b1, stop_a);
    repeat (clks_per_bit) @(negedge clk); // Rest of the stop bit.
    read_word(uart_base_addr + uart_status_offset, rd);
    check_value("busy after frame", 1'b0, rd[0]);
    end_test();

    start_test("uart_rx");
    byte_a = 8'(rand_bits(8));
    drive_rx_frame(byte_a);
    waited = 0;
    read_word(uart_base_addr + uart_status_offset, rd);
    while (rd[1] !== 1'b1) begin
      waited++;
      if (waited > 20) begin
        give_up("rx_full never set");
      end
      read_word(uart_base_addr + uart_status_offset, rd);
    end
    read_word(uart_base_addr + uart_data_offset, rd);
    check_value("data", {24'h0, byte_a}, rd);
    read_word(uart_base_addr + uart_status_offset, rd);
    check_value("rx_full after read", 1'b0, rd[1]);
    end_test();

    start_test("clint");
    read_word(clint_base_addr + clint_mtime_lo_offset, t0);
    c0 = ready_cycle;
    repeat (40) @(negedge clk);
    read_word(clint_base_addr + clint_mtime_lo_offset, t1);
    c1 = ready_cycle;
    check_true(t1 >= t0, "mtime went backwards");
    check_true((t1 - t0) <= (c1 - c0) / rtc_divider + 1, "mtime ran faster than the rtc tick");
    write_word(clint_base_addr + clint_msip_offset, 32'h1, '1);
    check_value("msip set", 1'b1, msip);
    write_word(clint_base_addr + clint_msip_offset, 32'h0, '1);
    check_value("msip clear", 1'b0, msip);
    read_word(clint_base_addr + clint_mtime_lo_offset, t0);
    target = t0 + 32'd20;
    write_word(clint_base_addr + clint_mtimecmp_lo_offset, target, '1);
    write_word(clint_base_addr + clint_mtimecmp_hi_offset, 32'h0, '1);
    read_word(clint_base_addr + clint_mtimecmp_lo_offset, rd);
    check_value("mtimecmp_lo", target, rd);
    check_value("mtip before compare", 1'b0, mtip);
    waited = 0;
    while (mtip !== 1'b1) begin
      waited++;
      if (waited > 40 * rtc_divider) begin
        give_up("mtip never rose");
      end
      @(negedge clk);
    end
    check_true(mtime >= {32'h0, target}, "mtip rose before mtime reached mtimecmp");
    write_word(clint_base_addr + clint_mtimecmp_hi_offset, '1, '1);
    write_word(clint_base_addr + clint_mtimecmp_lo_offset, '1, '1);
    check_value("mtip after clear", 1'b0, mtip);
    end_test();

    start_test("protocol");
    byte_a = 8'(rand_bits(8));
    byte_b = 8'(rand_bits(8));
    fork
      begin
        capture_tx_frame(got_a, stop_a);
        capture_tx_frame(got_b, stop_b);
      end
      begin
        write_word(uart_base_addr + uart_data_offset, {24'h0, byte_a}, 4'h1);
        c0 = ready_cycle;
        write_word(uart_base_addr + uart_data_offset, {24'h0, byte_b}, 4'h1);
        c1 = ready_cycle;
      end
    join
    check_value("held write latency", 10 * clks_per_bit + 1, c1 - c0); // Frame plus one.
    check_value("first byte", byte_a, got_a);
    check_value("first stop bit", 1'b1, stop_a);
    check_value("second byte", byte_b, got_b);
    check_value("second stop bit", 1'b1, stop_b);
    check_value("ready pulses", requests, ready_pulses);
    end_test();

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* hw/soc.sv */
`timescale 1ns/1ps

module soc import soc_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              mem_valid,
  input  logic [xlen-1:0]   mem_addr,
  input  logic [xlen-1:0]   mem_wdata,
  input  logic [xlen/8-1:0] mem_wstrb,
  output logic [xlen-1:0]   mem_rdata,
  output logic              mem_ready,
  input  logic              rx,
  output logic              tx,
  output logic              msip,
  output logic              mtip,
  output logic [63:0]       mtime
);
  logic                  bram_valid;
  logic [bram_depth-1:0] bram_index;
  logic [xlen-1:0]       bram_rdata;
  logic                  bram_ready;
  logic                  uart_valid;
  logic [xlen-1:0]       uart_offset;
  logic [xlen-1:0]       uart_rdata;
  logic                  uart_ready;
  logic                  clint_valid;
  logic [xlen-1:0]       clint_offset;
  logic [xlen-1:0]       clint_rdata;
  logic                  clint_ready;
  logic [xlen-1:0]       wdata;
  logic [xlen/8-1:0]     wstrb;

  bus_decoder u_bus_decoder (
    .mem_valid    (mem_valid),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_wstrb    (mem_wstrb),
    .mem_rdata    (mem_rdata),
    .mem_ready    (mem_ready),
    .bram_valid   (bram_valid),
    .bram_index   (bram_index),
    .bram_rdata   (bram_rdata),
    .bram_ready   (bram_ready),
    .uart_valid   (uart_valid),
    .uart_offset  (uart_offset),
    .uart_rdata   (uart_rdata),
    .uart_ready   (uart_ready),
    .clint_valid  (clint_valid),
    .clint_offset (clint_offset),
    .clint_rdata  (clint_rdata),
    .clint_ready  (clint_ready),
    .wdata        (wdata),
    .wstrb        (wstrb)
  );

  bram u_bram (
    .clk    (clk),
    .arst_n (arst_n),
    .valid  (bram_valid),
    .index  (bram_index),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .rdata  (bram_rdata),
    .ready  (bram_ready)
  );

  uart u_uart (
    .clk    (clk),
    .arst_n (arst_n),
    .valid  (uart_valid),
    .offset (uart_offset),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .rx     (rx),
    .rdata  (uart_rdata),
    .ready  (uart_ready),
    .tx     (tx)
  );

  clint u_clint (
    .clk    (clk),
    .arst_n (arst_n),
    .valid  (clint_valid),
    .offset (clint_offset),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .rdata  (clint_rdata),
    .ready  (clint_ready),
    .msip   (msip),
    .mtip   (mtip),
    .mtime  (mtime)
  );

endmodule

/* hw/clint.sv */
`timescale 1ns/1ps

module clint import soc_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              valid,
  input  logic [xlen-1:0]   offset,
  input  logic [xlen-1:0]   wdata,
  input  logic [xlen/8-1:0] wstrb,
  output logic [xlen-1:0]   rdata,
  output logic              ready,
  output logic              msip,
  output logic              mtip,
  output logic [63:0]       mtime
);
  logic [rtc_cnt_w-1:0] tick_cnt;
  logic                 tick;
  logic [63:0]          mtimecmp;
  logic                 accept;
  logic                 wr;
  logic                 mtime_wr;

  assign tick = tick_cnt == rtc_cnt_w'(rtc_divider - 1);
  assign accept = valid && !ready;
  assign wr = accept && (|wstrb); // Any strobe writes the full word.
  assign mtime_wr = wr && (offset == clint_mtime_lo_offset || offset == clint_mtime_hi_offset);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready <= 1'b0;
      tick_cnt <= '0;
      msip <= 1'b0;
      mtip <= 1'b0;
      mtime <= '0;
      mtimecmp <= '1;
    end else begin
      ready <= accept;
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      mtip <= mtime >= mtimecmp;
      if (tick) begin
        mtime <= mtime + 64'd1;
      end
      if (wr) begin
        case (offset)
          clint_msip_offset:        msip <= wdata[0];
          clint_mtimecmp_lo_offset: mtimecmp[31:0] <= wdata;
          clint_mtimecmp_hi_offset: mtimecmp[63:32] <= wdata;
          clint_mtime_lo_offset:    mtime <= {mtime[63:32], wdata}; // Overrides the tick.
          clint_mtime_hi_offset:    mtime <= {wdata, mtime[31:0]};
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      case (offset)
        clint_msip_offset:        rdata <= {{(xlen-1){1'b0}}, msip};
        clint_mtimecmp_lo_offset: rdata <= mtimecmp[31:0];
        clint_mtimecmp_hi_offset: rdata <= mtimecmp[63:32];
        clint_mtime_lo_offset:    rdata <= mtime[31:0];
        clint_mtime_hi_offset:    rdata <= mtime[63:32];
        default:                  rdata <= '0;
      endcase
    end
  end

  a_mtime_monotonic: assert property (@(posedge clk) disable iff (!arst_n)
    !mtime_wr |=> mtime >= $past(mtime));

endmodule

/* hw/uart.sv */
`timescale 1ns/1ps

module uart import soc_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              valid,
  input  logic [xlen-1:0]   offset,
  input  logic [xlen-1:0]   wdata,
  input  logic [xlen/8-1:0] wstrb,
  input  logic              rx,
  output logic [xlen-1:0]   rdata,
  output logic              ready,
  output logic              tx
);
  uart_tx_state_e        tx_state;
  logic [clks_cnt_w-1:0] tx_cnt;
  logic [2:0]            tx_bit;
  logic [7:0]            tx_shift;
  uart_rx_state_e        rx_state;
  logic [clks_cnt_w-1:0] rx_cnt;
  logic [2:0]            rx_bit;
  logic [7:0]            rx_shift;
  logic [7:0]            rx_byte;
  logic                  rx_full;
  logic [1:0]            rx_sync;
  logic                  tx_busy;
  logic                  data_wr;
  logic                  data_rd;
  logic                  accept;
  logic                  tx_last;
  logic                  rx_last;

  assign tx_busy = tx_state != tx_idle;
  assign data_wr = valid && (|wstrb) && (offset == uart_data_offset);
  assign accept = valid && !ready && !(data_wr && tx_busy); // Hold off writes mid frame.
  assign data_rd = accept && !(|wstrb) && (offset == uart_data_offset);
  assign tx_last = tx_cnt == clks_cnt_w'(clks_per_bit - 1);
  assign rx_last = rx_cnt == clks_cnt_w'(clks_per_bit - 1);

  ////////////////////
  // Register access

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata <= '0;
      if (!(|wstrb) && offset == uart_data_offset) begin
        rdata[7:0] <= rx_byte;
      end else if (!(|wstrb) && offset == uart_status_offset) begin
        rdata[1:0] <= {rx_full, tx_busy};
      end
    end
  end

  ////////////////////
  // Transmitter

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_state <= tx_idle;
      tx_cnt <= '0;
      tx_bit <= '0;
      tx_shift <= '0;
      tx <= 1'b1;
    end else begin
      tx_cnt <= tx_last ? '0 : tx_cnt + 1'b1;
      case (tx_state)
        tx_idle: begin
          tx_cnt <= '0;
          if (accept && data_wr) begin
            tx_state <= tx_start;
            tx_shift <= wdata[7:0];
            tx <= 1'b0; // Start bit.
          end
        end
        tx_start: begin
          if (tx_last) begin
            tx_state <= tx_data;
            tx_bit <= '0;
            tx <= tx_shift[0];
            tx_shift <= tx_shift >> 1;
          end
        end
        tx_data: begin
          if (tx_last && tx_bit == 3'd7) begin
            tx_state <= tx_stop;
            tx <= 1'b1;
          end else if (tx_last) begin
            tx_bit <= tx_bit + 1'b1;
            tx <= tx_shift[0];
            tx_shift <= tx_shift >> 1;
          end
        end
        default: begin
          if (tx_last) begin
            tx_state <= tx_idle;
          end
        end
      endcase
    end
  end

  ////////////////////
  // Receiver

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_sync <= 2'b11;
      rx_state <= rx_idle;
      rx_cnt <= '0;
      rx_bit <= '0;
      rx_shift <= '0;
      rx_byte <= '0;
      rx_full <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rx_cnt <= rx_cnt + 1'b1;
      if (data_rd) begin
        rx_full <= 1'b0;
      end
      case (rx_state)
        rx_idle: begin
          rx_cnt <= '0;
          if (!rx_sync[1]) begin
            rx_state <= rx_start;
          end
        end
        rx_start: begin
          if (rx_cnt == clks_cnt_w'(clks_per_bit/2 - 1)) begin // Middle of start bit.
            rx_cnt <= '0;
            rx_bit <= '0;
            rx_state <= rx_sync[1] ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (rx_last) begin
            rx_shift <= {rx_sync[1], rx_shift[7:1]}; // LSB first.
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) begin
              rx_state <= rx_stop;
            end
          end
        end
        default: begin
          if (rx_last) begin
            rx_state <= rx_idle;
            if (rx_sync[1]) begin
              rx_byte <= rx_shift;
              rx_full <= 1'b1; // New byte wins over a clearing read.
            end
          end
        end
      endcase
    end
  end

  a_tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
    !tx_busy |-> tx);

  // An acknowledged data write has just started a fresh frame.
  a_no_ready_busy: assert property (@(posedge clk) disable iff (!arst_n)
    (ready && data_wr) |-> (tx_state == tx_start && tx_cnt == '0));

endmodule

/* hw/bram.sv */
`timescale 1ns/1ps

module bram import soc_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  valid,
  input  logic [bram_depth-1:0] index,
  input  logic [xlen-1:0]       wdata,
  input  logic [xlen/8-1:0]     wstrb,
  output logic [xlen-1:0]       rdata,
  output logic                  ready
);
  logic [xlen-1:0] mem [2**bram_depth];
  logic            accept;

  assign accept = valid && !ready; // One access per request.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= accept;
    end
  end

  ////////////////////
  // Storage

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata <= mem[index]; // Old word on a write.
      for (int i = 0; i < xlen/8; i++) begin
        if (wstrb[i]) begin
          mem[index][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

/* hw/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder import soc_pkg::*; (
  input  logic                  mem_valid,
  input  logic [xlen-1:0]       mem_addr,
  input  logic [xlen-1:0]       mem_wdata,
  input  logic [xlen/8-1:0]     mem_wstrb,
  output logic [xlen-1:0]       mem_rdata,
  output logic                  mem_ready,
  output logic                  bram_valid,
  output logic [bram_depth-1:0] bram_index,
  input  logic [xlen-1:0]       bram_rdata,
  input  logic                  bram_ready,
  output logic                  uart_valid,
  output logic [xlen-1:0]       uart_offset,
  input  logic [xlen-1:0]       uart_rdata,
  input  logic                  uart_ready,
  output logic                  clint_valid,
  output logic [xlen-1:0]       clint_offset,
  input  logic [xlen-1:0]       clint_rdata,
  input  logic                  clint_ready,
  output logic [xlen-1:0]       wdata,
  output logic [xlen/8-1:0]     wstrb
);
  logic in_uart;
  logic in_clint;

  assign in_uart = (mem_addr >= uart_base_addr) && (mem_addr < uart_top_addr);
  assign in_clint = (mem_addr >= clint_base_addr) && (mem_addr < clint_top_addr);

  assign uart_valid = mem_valid && in_uart;
  assign clint_valid = mem_valid && in_clint;
  assign bram_valid = mem_valid && !in_uart && !in_clint; // Everything else aliases BRAM.

  assign uart_offset = mem_addr ^ uart_base_addr;
  assign clint_offset = mem_addr ^ clint_base_addr;
  assign bram_index = mem_addr[bram_depth+1:2];
  assign wdata = mem_wdata;
  assign wstrb = mem_wstrb;

  always_comb begin
    mem_ready = bram_ready || uart_ready || clint_ready;
    if (bram_ready) begin
      mem_rdata = bram_rdata;
    end else if (uart_ready) begin
      mem_rdata = uart_rdata;
    end else if (clint_ready) begin
      mem_rdata = clint_rdata;
    end else begin
      mem_rdata = '0;
    end
  end

  // Targets answer independently, so only one may be active at a time.
  always_comb begin
    a_one_valid: assert #0 ($onehot0({bram_valid, uart_valid, clint_valid}))
      else $error("More than one target valid");
    a_one_ready: assert #0 ($onehot0({bram_ready, uart_ready, clint_ready}))
      else $error("More than one target ready");
  end

endmodule

/* hw/soc_pkg.sv */
package soc_pkg;

  ////////////////////
  // Bus and address map

  localparam int xlen = 32;
  localparam int bram_depth = 10; // Word address bits.

  localparam logic [xlen-1:0] uart_base_addr = 32'h1000_0000;
  localparam logic [xlen-1:0] uart_top_addr = uart_base_addr + 32'd16;
  localparam logic [xlen-1:0] clint_base_addr = 32'h0200_0000;
  localparam logic [xlen-1:0] clint_top_addr = clint_base_addr + 32'h1_0000;

  ////////////////////
  // UART

  localparam logic [xlen-1:0] uart_data_offset = 32'h0;
  localparam logic [xlen-1:0] uart_status_offset = 32'h4;
  localparam int clks_per_bit = 8; // Short bit time for simulation.
  localparam int clks_cnt_w = $clog2(clks_per_bit);

  typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} uart_tx_state_e;
  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} uart_rx_state_e;

  ////////////////////
  // CLINT

  localparam logic [xlen-1:0] clint_msip_offset = 32'h0;
  localparam logic [xlen-1:0] clint_mtimecmp_lo_offset = 32'h4000;
  localparam logic [xlen-1:0] clint_mtimecmp_hi_offset = 32'h4004;
  localparam logic [xlen-1:0] clint_mtime_lo_offset = 32'hBFF8;
  localparam logic [xlen-1:0] clint_mtime_hi_offset = 32'hBFFC;

  localparam int rtc_divider = 4; // clk cycles per mtime tick.
  localparam int rtc_cnt_w = $clog2(rtc_divider);

endpackage
